// ==== rtl/mci_pkg.sv ====
/*
  Shared types for the boot sequencer. The state encoding is 4 bits and
  BOOT_UNKNOWN is reserved for a corrupt state register.
*/

package mci_pkg;

  //////////////////////////////////////////////////
  // Boot sequencer states
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    BOOT_IDLE             = 4'h0,
    BOOT_OTP_FC           = 4'h1,
    BOOT_LCC              = 4'h2,
    BOOT_BREAKPOINT_CHECK = 4'h3,
    BOOT_BREAKPOINT       = 4'h4,
    BOOT_MCU              = 4'h5,
    BOOT_WAIT_CPTRA_GO    = 4'h6,
    BOOT_CPTRA            = 4'h7,
    BOOT_WAIT_MCU_RST_REQ = 4'h8,
    BOOT_HALT_MCU         = 4'h9,
    BOOT_WAIT_MCU_HALTED  = 4'ha,
    BOOT_RST_MCU          = 4'hb,
    // Only reached from an unused encoding
    BOOT_UNKNOWN          = 4'hf
  } mci_boot_fsm_state_e;

  //////////////////////////////////////////////////
  // Sizing defaults
  //////////////////////////////////////////////////

  // MCU stays in reset for at least 2**width cycles
  localparam int MIN_MCU_RST_COUNTER_WIDTH_DEF = 4;

endpackage

// ==== rtl/mci_sync_if.sv ====
/*
  Synchronised status levels from the fuse, life-cycle and SoC domains.
  Levels only, there is no handshake on this bundle.
*/

`timescale 1ns/1ps

interface mci_sync_if;

  logic fc_opt_done;
  logic lc_done;
  logic brkpoint;
  logic no_rom_config;

  // Synchroniser bank side
  modport src (
    output fc_opt_done, lc_done, brkpoint, no_rom_config
  );

  // Sequencer side
  modport dst (
    input fc_opt_done, lc_done, brkpoint, no_rom_config
  );

endinterface

// ==== rtl/mci_sync_bank.sv ====
/*
  Two-flop synchronisers for the asynchronous status levels.
  Each input shows up on the interface two clk edges after it changes.
  Inputs must be glitch-free levels held for more than one cycle.
*/

`timescale 1ns/1ps

module mci_sync_bank (
  input  logic   clk,
  input  logic   mci_rst_b,
  input  logic   fc_opt_done_i,
  input  logic   lc_done_i,
  input  logic   brkpoint_i,
  input  logic   no_rom_config_i,
  mci_sync_if.src sync
);

  logic [3:0] async_in;
  logic [3:0] meta_q;
  logic [3:0] sync_q;

  // Bit order is fixed by the unpacking below
  assign async_in = {no_rom_config_i, brkpoint_i, lc_done_i, fc_opt_done_i};

  //////////////////////////////////////////////////
  // Two-stage flop chains
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= async_in;
      sync_q <= meta_q;
    end
  end

  assign sync.fc_opt_done   = sync_q[0];
  assign sync.lc_done       = sync_q[1];
  assign sync.brkpoint      = sync_q[2];
  assign sync.no_rom_config = sync_q[3];

endmodule

// ==== rtl/mci_rst_timer.sv ====
/*
  Minimum MCU reset timer. start_i clears the count and elapsed_o.
  elapsed_o rises one cycle after the count saturates at all ones and
  holds until the next start_i.
*/

`timescale 1ns/1ps

module mci_rst_timer #(
  parameter int MIN_MCU_RST_COUNTER_WIDTH = mci_pkg::MIN_MCU_RST_COUNTER_WIDTH_DEF
) (
  input  logic clk,
  input  logic mci_rst_b,
  input  logic start_i,
  output logic elapsed_o
);

  typedef logic [MIN_MCU_RST_COUNTER_WIDTH-1:0] rst_cnt_t;

  rst_cnt_t rst_cnt_q;

  //////////////////////////////////////////////////
  // Saturating counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      rst_cnt_q <= '0;
      elapsed_o <= 1'b0;
    end else if (start_i) begin
      rst_cnt_q <= '0;
      elapsed_o <= 1'b0;
    end else if (rst_cnt_q != '1) begin
      rst_cnt_q <= rst_cnt_q + 1'b1;
    end else begin
      // Count is saturated, flag stays set until restarted
      elapsed_o <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // A zero-width counter would give no minimum reset time at all
  initial begin
    assert (MIN_MCU_RST_COUNTER_WIDTH > 0)
      else $fatal(1, "MIN_MCU_RST_COUNTER_WIDTH must be greater than zero");
  end

endmodule

// ==== rtl/mci_halt_ctrl.sv ====
/*
  MCU halt exchange. start_i raises the request, which drops after the
  acknowledge. done_o pulses one cycle after the halt status is seen.
  A start_i that arrives mid-exchange is ignored.
*/

`timescale 1ns/1ps

module mci_halt_ctrl (
  input  logic clk,
  input  logic mci_rst_b,
  input  logic start_i,
  input  logic mcu_cpu_halt_ack_i,
  input  logic mcu_cpu_halt_status_i,
  output logic mcu_cpu_halt_req_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    HALT_IDLE,
    HALT_REQ,
    HALT_WAIT_STATUS
  } halt_state_e;

  halt_state_e halt_state;

  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      halt_state         <= HALT_IDLE;
      mcu_cpu_halt_req_o <= 1'b0;
      done_o             <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (halt_state)
        HALT_IDLE: begin
          if (start_i) begin
            halt_state         <= HALT_REQ;
            mcu_cpu_halt_req_o <= 1'b1;
          end
        end
        HALT_REQ: begin
          // Request held until the MCU acknowledges it
          if (mcu_cpu_halt_ack_i) begin
            halt_state         <= HALT_WAIT_STATUS;
            mcu_cpu_halt_req_o <= 1'b0;
          end
        end
        HALT_WAIT_STATUS: begin
          if (mcu_cpu_halt_status_i) begin
            halt_state <= HALT_IDLE;
            done_o     <= 1'b1;
          end
        end
        default: begin
          halt_state         <= HALT_IDLE;
          mcu_cpu_halt_req_o <= 1'b0;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    !(done_o && mcu_cpu_halt_req_o))
    else $error("halt done reported while halt request still high");

endmodule

// ==== rtl/mci_boot_seqr.sv ====
/*
  Boot sequencer FSM. Go strobes and the MCU reset request are one-cycle
  pulses and only count in their waiting state. Reset and init outputs
  are registered and follow the state by one cycle.
*/

`timescale 1ns/1ps

module mci_boot_seqr (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  mci_sync_if.dst                      sync,
  input  logic                         mci_bootfsm_go_i,
  input  logic                         caliptra_boot_go_i,
  input  logic                         mcu_rst_req_i,
  input  logic                         mcu_sram_fw_exec_region_lock_i,
  input  logic                         timer_elapsed_i,
  input  logic                         halt_done_i,
  output logic                         timer_start_o,
  output logic                         halt_start_o,
  output logic                         fc_opt_init_o,
  output logic                         lc_init_o,
  output logic                         mcu_rst_b_o,
  output logic                         cptra_rst_b_o,
  output logic                         mcu_reset_once_o,
  output mci_pkg::mci_boot_fsm_state_e boot_fsm_o
);

  mci_pkg::mci_boot_fsm_state_e boot_fsm_nxt;
  mci_pkg::mci_boot_fsm_state_e boot_fsm_prev;

  logic fc_opt_init_nxt;
  logic lc_init_nxt;
  logic mcu_rst_b_nxt;
  logic cptra_rst_b_nxt;
  logic mcu_reset_once_nxt;

  //////////////////////////////////////////////////
  // State and output registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      boot_fsm_o       <= mci_pkg::BOOT_IDLE;
      boot_fsm_prev    <= mci_pkg::BOOT_IDLE;
      fc_opt_init_o    <= 1'b0;
      lc_init_o        <= 1'b0;
      mcu_rst_b_o      <= 1'b0;
      cptra_rst_b_o    <= 1'b0;
      mcu_reset_once_o <= 1'b0;
    end else begin
      boot_fsm_o <= boot_fsm_nxt;
      // Track the state we came from on every real transition
      if (boot_fsm_nxt != boot_fsm_o) begin
        boot_fsm_prev <= boot_fsm_o;
      end
      fc_opt_init_o    <= fc_opt_init_nxt;
      lc_init_o        <= lc_init_nxt;
      mcu_rst_b_o      <= mcu_rst_b_nxt;
      cptra_rst_b_o    <= cptra_rst_b_nxt;
      mcu_reset_once_o <= mcu_reset_once_nxt;
    end
  end

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////
  always_comb begin
    boot_fsm_nxt       = boot_fsm_o;
    fc_opt_init_nxt    = fc_opt_init_o;
    lc_init_nxt        = lc_init_o;
    mcu_rst_b_nxt      = mcu_rst_b_o;
    cptra_rst_b_nxt    = cptra_rst_b_o;
    mcu_reset_once_nxt = mcu_reset_once_o;
    case (boot_fsm_o)
      mci_pkg::BOOT_IDLE: begin
        boot_fsm_nxt = mci_pkg::BOOT_OTP_FC;
      end
      mci_pkg::BOOT_OTP_FC: begin
        fc_opt_init_nxt = 1'b1;
        if (sync.fc_opt_done) begin
          boot_fsm_nxt = mci_pkg::BOOT_LCC;
        end
      end
      mci_pkg::BOOT_LCC: begin
        lc_init_nxt = 1'b1;
        if (sync.lc_done) begin
          boot_fsm_nxt = mci_pkg::BOOT_BREAKPOINT_CHECK;
        end
      end
      mci_pkg::BOOT_BREAKPOINT_CHECK: begin
        if (sync.brkpoint) begin
          boot_fsm_nxt = mci_pkg::BOOT_BREAKPOINT;
        end else if (sync.no_rom_config) begin
          boot_fsm_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
        end else begin
          boot_fsm_nxt = mci_pkg::BOOT_MCU;
        end
      end
      mci_pkg::BOOT_BREAKPOINT: begin
        // Debugger releases the sequence with the go strobe
        if (mci_bootfsm_go_i) begin
          if (sync.no_rom_config) begin
            boot_fsm_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
          end else begin
            boot_fsm_nxt = mci_pkg::BOOT_MCU;
          end
        end
      end
      mci_pkg::BOOT_MCU: begin
        mcu_rst_b_nxt = 1'b1;
        // After a reset-request cycle the security core is already running
        if (boot_fsm_prev == mci_pkg::BOOT_RST_MCU) begin
          boot_fsm_nxt = mci_pkg::BOOT_WAIT_MCU_RST_REQ;
        end else begin
          boot_fsm_nxt = mci_pkg::BOOT_WAIT_CPTRA_GO;
        end
      end
      mci_pkg::BOOT_WAIT_CPTRA_GO: begin
        if (caliptra_boot_go_i) begin
          boot_fsm_nxt = mci_pkg::BOOT_CPTRA;
        end
      end
      mci_pkg::BOOT_CPTRA: begin
        cptra_rst_b_nxt = 1'b1;
        boot_fsm_nxt    = mci_pkg::BOOT_WAIT_MCU_RST_REQ;
      end
      mci_pkg::BOOT_WAIT_MCU_RST_REQ: begin
        if (mcu_rst_req_i) begin
          boot_fsm_nxt = mci_pkg::BOOT_HALT_MCU;
        end
      end
      mci_pkg::BOOT_HALT_MCU: begin
        if (halt_done_i) begin
          boot_fsm_nxt = mci_pkg::BOOT_WAIT_MCU_HALTED;
        end
      end
      mci_pkg::BOOT_WAIT_MCU_HALTED: begin
        boot_fsm_nxt = mci_pkg::BOOT_RST_MCU;
      end
      mci_pkg::BOOT_RST_MCU: begin
        mcu_rst_b_nxt      = 1'b0;
        mcu_reset_once_nxt = 1'b1;
        // Min reset time done and new firmware locked in SRAM
        if (timer_elapsed_i && mcu_sram_fw_exec_region_lock_i) begin
          boot_fsm_nxt = mci_pkg::BOOT_MCU;
        end
      end
      default: begin
        boot_fsm_nxt = mci_pkg::BOOT_UNKNOWN;
      end
    endcase
  end

  // Start pulses line up with the edge that enters the target state
  assign timer_start_o = (boot_fsm_nxt == mci_pkg::BOOT_RST_MCU) &&
                         (boot_fsm_o != mci_pkg::BOOT_RST_MCU);
  assign halt_start_o  = (boot_fsm_nxt == mci_pkg::BOOT_HALT_MCU) &&
                         (boot_fsm_o != mci_pkg::BOOT_HALT_MCU);

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    !$isunknown(boot_fsm_o) && (boot_fsm_o != mci_pkg::BOOT_UNKNOWN))
    else $error("boot FSM in an invalid state");

endmodule

// ==== rtl/mci_boot_top.sv ====
/*
  Boot sequencing top level. Fuse, life-cycle, breakpoint and no-ROM
  inputs may be asynchronous. Go strobes, the reset request and the
  region lock must be synchronous to clk.
*/

`timescale 1ns/1ps

module mci_boot_top #(
  parameter int MIN_MCU_RST_COUNTER_WIDTH = mci_pkg::MIN_MCU_RST_COUNTER_WIDTH_DEF
) (
  input  logic                         clk,
  input  logic                         mci_rst_b,
  // Asynchronous status levels
  input  logic                         fc_opt_done_i,
  input  logic                         lc_done_i,
  input  logic                         mci_boot_seq_brkpoint_i,
  input  logic                         mcu_no_rom_config_i,
  // Synchronous strobes and levels
  input  logic                         mci_bootfsm_go_i,
  input  logic                         caliptra_boot_go_i,
  input  logic                         mcu_rst_req_i,
  input  logic                         mcu_sram_fw_exec_region_lock_i,
  // Init and reset controls
  output logic                         fc_opt_init_o,
  output logic                         lc_init_o,
  output logic                         mcu_rst_b_o,
  output logic                         cptra_rst_b_o,
  output logic                         mcu_reset_once_o,
  // MCU halt exchange
  output logic                         mcu_cpu_halt_req_o,
  input  logic                         mcu_cpu_halt_ack_i,
  input  logic                         mcu_cpu_halt_status_i,
  output mci_pkg::mci_boot_fsm_state_e boot_fsm_o
);

  logic timer_start;
  logic timer_elapsed;
  logic halt_start;
  logic halt_done;

  mci_sync_if sync_bus ();

  mci_sync_bank i_sync_bank (
    .clk             (clk),
    .mci_rst_b       (mci_rst_b),
    .fc_opt_done_i   (fc_opt_done_i),
    .lc_done_i       (lc_done_i),
    .brkpoint_i      (mci_boot_seq_brkpoint_i),
    .no_rom_config_i (mcu_no_rom_config_i),
    .sync            (sync_bus.src)
  );

  mci_rst_timer #(
    .MIN_MCU_RST_COUNTER_WIDTH (MIN_MCU_RST_COUNTER_WIDTH)
  ) i_rst_timer (
    .clk       (clk),
    .mci_rst_b (mci_rst_b),
    .start_i   (timer_start),
    .elapsed_o (timer_elapsed)
  );

  mci_halt_ctrl i_halt_ctrl (
    .clk                   (clk),
    .mci_rst_b             (mci_rst_b),
    .start_i               (halt_start),
    .mcu_cpu_halt_ack_i    (mcu_cpu_halt_ack_i),
    .mcu_cpu_halt_status_i (mcu_cpu_halt_status_i),
    .mcu_cpu_halt_req_o    (mcu_cpu_halt_req_o),
    .done_o                (halt_done)
  );

  mci_boot_seqr i_boot_seqr (
    .clk                            (clk),
    .mci_rst_b                      (mci_rst_b),
    .sync                           (sync_bus.dst),
    .mci_bootfsm_go_i               (mci_bootfsm_go_i),
    .caliptra_boot_go_i             (caliptra_boot_go_i),
    .mcu_rst_req_i                  (mcu_rst_req_i),
    .mcu_sram_fw_exec_region_lock_i (mcu_sram_fw_exec_region_lock_i),
    .timer_elapsed_i                (timer_elapsed),
    .halt_done_i                    (halt_done),
    .timer_start_o                  (timer_start),
    .halt_start_o                   (halt_start),
    .fc_opt_init_o                  (fc_opt_init_o),
    .lc_init_o                      (lc_init_o),
    .mcu_rst_b_o                    (mcu_rst_b_o),
    .cptra_rst_b_o                  (cptra_rst_b_o),
    .mcu_reset_once_o               (mcu_reset_once_o),
    .boot_fsm_o                     (boot_fsm_o)
  );

endmodule

// ==== tests/mci_boot_tb.sv ====
/*
  Testbench for the boot sequencer with fuse, life-cycle and MCU models.
  Concurrent assertions do the checking. Inputs change on the falling edge
  and the first failing check ends the run.
*/

`timescale 1ns/1ps

module mci_boot_tb;

  localparam int RST_CNT_W      = 4;
  localparam int MIN_RST_CYCLES = 1 << RST_CNT_W;
  localparam int WAIT_LIMIT     = 300;
  localparam int GO_BOOTFSM     = 0;
  localparam int GO_CPTRA       = 1;
  localparam int RST_REQ        = 2;

  logic clk = 1'b0;
  logic mci_rst_b;
  logic brkpoint_i, no_rom_i, bootfsm_go_i, cptra_go_i, rst_req_i, fw_lock_i;
  logic fc_done_i = 1'b0;
  logic lc_done_i = 1'b0;
  logic halt_ack_i = 1'b0;
  logic halt_status_i = 1'b0;
  logic fc_init_o, lc_init_o, mcu_rst_b_o, cptra_rst_b_o, reset_once_o, halt_req_o;
  mci_pkg::mci_boot_fsm_state_e boot_fsm_o;

  integer seed;
  int     fc_cnt, lc_cnt, halt_cnt, low_cycles;
  logic   fc_armed = 1'b0;
  logic   lc_armed = 1'b0;
  logic   halt_armed = 1'b0;
  logic   cptra_go_seen, bkpt_go_seen, halt_seen;

  always #5 clk = ~clk;

  mci_boot_top #(.MIN_MCU_RST_COUNTER_WIDTH(RST_CNT_W)) i_dut (
    .clk (clk), .mci_rst_b (mci_rst_b),
    .fc_opt_done_i (fc_done_i), .lc_done_i (lc_done_i),
    .mci_boot_seq_brkpoint_i (brkpoint_i), .mcu_no_rom_config_i (no_rom_i),
    .mci_bootfsm_go_i (bootfsm_go_i), .caliptra_boot_go_i (cptra_go_i),
    .mcu_rst_req_i (rst_req_i), .mcu_sram_fw_exec_region_lock_i (fw_lock_i),
    .fc_opt_init_o (fc_init_o), .lc_init_o (lc_init_o),
    .mcu_rst_b_o (mcu_rst_b_o), .cptra_rst_b_o (cptra_rst_b_o),
    .mcu_reset_once_o (reset_once_o), .mcu_cpu_halt_req_o (halt_req_o),
    .mcu_cpu_halt_ack_i (halt_ack_i), .mcu_cpu_halt_status_i (halt_status_i),
    .boot_fsm_o (boot_fsm_o)
  );

  //////////////////////////////////////////////////
  // Fuse and life-cycle models
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!mci_rst_b) begin
      fc_done_i <= 1'b0;
      fc_armed  <= 1'b0;
    end else if (fc_init_o && !fc_armed) begin
      fc_armed <= 1'b1;
      fc_cnt   <= ($random(seed) & 15) + 1;
    end else if (fc_armed && !fc_done_i) begin
      if (fc_cnt == 0) fc_done_i <= 1'b1;
      else fc_cnt <= fc_cnt - 1;
    end
  end

  always @(negedge clk) begin
    if (!mci_rst_b) begin
      lc_done_i <= 1'b0;
      lc_armed  <= 1'b0;
    end else if (lc_init_o && !lc_armed) begin
      lc_armed <= 1'b1;
      lc_cnt   <= ($random(seed) & 15) + 1;
    end else if (lc_armed && !lc_done_i) begin
      if (lc_cnt == 0) lc_done_i <= 1'b1;
      else lc_cnt <= lc_cnt - 1;
    end
  end

  // MCU model, status drops again once the MCU is held in reset
  always @(negedge clk) begin
    if (!mci_rst_b) begin
      halt_ack_i    <= 1'b0;
      halt_status_i <= 1'b0;
      halt_armed    <= 1'b0;
    end else if (halt_req_o && !halt_armed) begin
      halt_armed <= 1'b1;
      halt_cnt   <= ($random(seed) & 7) + 1;
    end else if (halt_armed && !halt_ack_i && !halt_status_i) begin
      if (halt_cnt == 0) halt_ack_i <= 1'b1;
      else halt_cnt <= halt_cnt - 1;
    end else if (halt_ack_i && !halt_req_o) begin
      halt_ack_i    <= 1'b0;
      halt_status_i <= 1'b1;
    end else if (halt_status_i && !mcu_rst_b_o) begin
      halt_status_i <= 1'b0;
      halt_armed    <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Monitor state for the checks
  //////////////////////////////////////////////////
  always @(posedge clk or negedge mci_rst_b) begin
    if (!mci_rst_b) begin
      cptra_go_seen <= 1'b0;
      bkpt_go_seen  <= 1'b0;
      halt_seen     <= 1'b0;
      low_cycles    <= 0;
    end else begin
      if (cptra_go_i && boot_fsm_o == mci_pkg::BOOT_WAIT_CPTRA_GO) cptra_go_seen <= 1'b1;
      if (bootfsm_go_i && boot_fsm_o == mci_pkg::BOOT_BREAKPOINT) bkpt_go_seen <= 1'b1;
      if (rst_req_i) halt_seen <= 1'b0;
      else if (halt_status_i) halt_seen <= 1'b1;
      low_cycles <= mcu_rst_b_o ? 0 : low_cycles + 1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  assert property (@(posedge clk) (!mci_rst_b || boot_fsm_o == mci_pkg::BOOT_IDLE) |->
    (boot_fsm_o == mci_pkg::BOOT_IDLE && !fc_init_o && !lc_init_o && !mcu_rst_b_o &&
     !cptra_rst_b_o && !reset_once_o && !halt_req_o))
    else report_mismatch("outputs not low in reset or idle");
  assert property (@(posedge clk) disable iff (!mci_rst_b) $rose(lc_init_o) |-> fc_done_i)
    else report_mismatch("lc_init_o rose before fuse done");
  assert property (@(posedge clk) disable iff (!mci_rst_b) $rose(mcu_rst_b_o) |-> lc_done_i)
    else report_mismatch("MCU reset released before life-cycle done");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    $rose(cptra_rst_b_o) |-> cptra_go_seen)
    else report_mismatch("security core released without a go strobe");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (brkpoint_i && ($rose(mcu_rst_b_o) || $rose(cptra_rst_b_o))) |-> bkpt_go_seen)
    else report_mismatch("reset released at breakpoint without go");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (boot_fsm_o == mci_pkg::BOOT_BREAKPOINT && !bootfsm_go_i) |=>
    boot_fsm_o == mci_pkg::BOOT_BREAKPOINT)
    else report_mismatch("breakpoint left without go strobe");
  assert property (@(posedge clk) disable iff (!mci_rst_b) no_rom_i |-> !mcu_rst_b_o)
    else report_mismatch("MCU released in no-ROM configuration");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (boot_fsm_o == mci_pkg::BOOT_WAIT_MCU_RST_REQ && rst_req_i) |=> halt_req_o)
    else report_mismatch("halt request missing after MCU reset request");
  assert property (@(posedge clk) disable iff (!mci_rst_b) $rose(halt_req_o) |->
    ($past(boot_fsm_o) == mci_pkg::BOOT_WAIT_MCU_RST_REQ && $past(rst_req_i)))
    else report_mismatch("halt request without an accepted reset request");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (halt_req_o && !halt_ack_i) |=> halt_req_o)
    else report_mismatch("halt request dropped before acknowledge");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    $fell(mcu_rst_b_o) |-> (halt_seen && reset_once_o))
    else report_mismatch("MCU reset before halt status or without reset-once flag");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    ($rose(mcu_rst_b_o) && reset_once_o) |-> low_cycles >= MIN_RST_CYCLES)
    else report_mismatch("MCU reset shorter than the minimum time");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (reset_once_o && !mcu_rst_b_o && !fw_lock_i) |=> !mcu_rst_b_o)
    else report_mismatch("MCU released before firmware region lock");
  assert property (@(posedge clk) disable iff (!mci_rst_b) cptra_rst_b_o |=> cptra_rst_b_o)
    else report_mismatch("security core reset asserted again");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    boot_fsm_o == mci_pkg::BOOT_WAIT_MCU_RST_REQ |->
    (cptra_rst_b_o && (mcu_rst_b_o != no_rom_i)))
    else report_mismatch("wrong reset outputs while waiting for reset request");
  assert property (@(posedge clk) disable iff (!mci_rst_b)
    (boot_fsm_o == mci_pkg::BOOT_MCU && reset_once_o) |=>
    boot_fsm_o == mci_pkg::BOOT_WAIT_MCU_RST_REQ)
    else report_mismatch("no return to reset-request wait after MCU reset");

  //////////////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////////////
  task automatic stop_with_fail(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_fail($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  task automatic wait_state(input mci_pkg::mci_boot_fsm_state_e st);
    int n;
    n = 0;
    while (boot_fsm_o != st) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_fail($sformatf("Timed out waiting for %s", st.name()));
    end
  endtask

  task automatic pulse_strobe(input int which);
    @(negedge clk);
    case (which)
      GO_BOOTFSM: bootfsm_go_i <= 1'b1;
      GO_CPTRA:   cptra_go_i <= 1'b1;
      default:    rst_req_i <= 1'b1;
    endcase
    @(negedge clk);
    bootfsm_go_i <= 1'b0;
    cptra_go_i   <= 1'b0;
    rst_req_i    <= 1'b0;
  endtask

  task automatic apply_reset(input logic brk, input logic no_rom);
    @(negedge clk);
    mci_rst_b  <= 1'b0;
    brkpoint_i <= brk;
    no_rom_i   <= no_rom;
    fw_lock_i  <= 1'b0;
    repeat (8) @(negedge clk);
    mci_rst_b <= 1'b1;
  endtask

  // Lock set shortly after reset entry, or well after the timer ran out
  task automatic mcu_reset_cycle(input logic lock_early);
    int hold;
    hold = lock_early ? 2 : 3 * MIN_RST_CYCLES;
    @(negedge clk);
    fw_lock_i <= 1'b0;
    pulse_strobe(RST_REQ);
    wait_state(mci_pkg::BOOT_RST_MCU);
    repeat (hold) @(negedge clk);
    fw_lock_i <= 1'b1;
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    seed         = 32'h7a88ad43;
    mci_rst_b    = 1'b0;
    brkpoint_i   = 1'b0;
    no_rom_i     = 1'b0;
    bootfsm_go_i = 1'b0;
    cptra_go_i   = 1'b0;
    rst_req_i    = 1'b0;
    fw_lock_i    = 1'b0;

    // Normal path, early strobes must be ignored
    apply_reset(1'b0, 1'b0);
    wait_state(mci_pkg::BOOT_OTP_FC);
    pulse_strobe(GO_CPTRA);
    pulse_strobe(RST_REQ);
    wait_state(mci_pkg::BOOT_WAIT_CPTRA_GO);
    pulse_strobe(GO_CPTRA);
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ);
    mcu_reset_cycle(1'b1);
    mcu_reset_cycle(1'b0);

    // Breakpoint path
    apply_reset(1'b1, 1'b0);
    wait_state(mci_pkg::BOOT_OTP_FC);
    pulse_strobe(GO_BOOTFSM);
    wait_state(mci_pkg::BOOT_BREAKPOINT);
    repeat (10) @(negedge clk);
    pulse_strobe(GO_BOOTFSM);
    wait_state(mci_pkg::BOOT_WAIT_CPTRA_GO);
    pulse_strobe(GO_CPTRA);
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ);

    // No-ROM path
    apply_reset(1'b0, 1'b1);
    wait_state(mci_pkg::BOOT_WAIT_CPTRA_GO);
    repeat (4) @(negedge clk);
    pulse_strobe(GO_CPTRA);
    wait_state(mci_pkg::BOOT_WAIT_MCU_RST_REQ);
    repeat (4) @(negedge clk);

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== mci_boot_top.f ====
rtl/mci_pkg.sv
rtl/mci_sync_if.sv
rtl/mci_sync_bank.sv
rtl/mci_rst_timer.sv
rtl/mci_halt_ctrl.sv
rtl/mci_boot_seqr.sv
rtl/mci_boot_top.sv
tests/mci_boot_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the boot sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module mci_boot_tb -Mdir obj_dir -f mci_boot_top.f

sim_out=$(./obj_dir/Vmci_boot_tb 2>&1 || true)
echo "$sim_out"

if grep -qF -- '>>> PASS' <<< "$sim_out"; then
  exit 0
else
  exit 1
fi
